/* source/pic_pkg.sv */
// Shared widths, bit positions and command codes for an 8086-mode interrupt controller
// Single device only: cascade, poll, rotation and special mask fields are not decoded
// ICW4 contributes only its AEOI bit
package pic_pkg;

    localparam int NUM_IRQ = 8;

    typedef logic [7:0]         data_t;
    typedef logic [NUM_IRQ-1:0] irq_vec_t;
    typedef logic [2:0]         irq_level_t;
    typedef logic [4:0]         vector_base_t;

    typedef enum logic [1:0] {INIT_READY, INIT_ICW2, INIT_ICW4} init_state_t;
    typedef enum logic [1:0] {ACK_IDLE, ACK_FIRST, ACK_WAIT, ACK_SECOND} ack_state_t;

    // Command selection at address 0
    localparam int ICW1_SELECT_BIT = 4;
    localparam int OCW3_SELECT_BIT = 3;

    // ICW1 and ICW4 fields
    localparam int ICW1_LTIM_BIT = 3;
    localparam int ICW1_IC4_BIT  = 0;
    localparam int ICW4_AEOI_BIT = 1;

    // OCW3 read register select
    localparam int OCW3_RR_BIT  = 1;
    localparam int OCW3_RIS_BIT = 0;

    // OCW2 command field and EOI codes
    localparam int         OCW2_CODE_MSB    = 7;
    localparam int         OCW2_CODE_LSB    = 5;
    localparam logic [2:0] EOI_NON_SPECIFIC = 3'b001;
    localparam logic [2:0] EOI_SPECIFIC     = 3'b011;

    localparam irq_vec_t   IMR_RESET      = 8'hFF;
    // Reported when an acknowledge finds nothing pending
    localparam irq_level_t SPURIOUS_LEVEL = 3'd7;

endpackage

/* source/pic_sequencer.sv */
`timescale 1ns/1ps
// Write decoder, initialization tracking and INTA sequencer
// OCW writes that arrive before initialization completes are dropped
// INTA edges are found from one registered sample per clock
module pic_sequencer (
    input  logic            clock,
    input  logic            reset,
    input  logic            write_enable,
    input  logic            address,
    input  pic_pkg::data_t  data_in,
    input  logic            interrupt_acknowledge_n,
    input  logic            request_pending,
    input  logic            needs_icw4,
    output logic            write_icw1,
    output logic            write_icw2,
    output logic            write_icw4,
    output logic            write_ocw1,
    output logic            write_ocw2,
    output logic            write_ocw3,
    output logic            latch_in_service,
    output logic            end_of_acknowledge,
    output logic            vector_phase,
    output logic            freeze,
    output logic            interrupt_to_cpu
);

    pic_pkg::init_state_t  init_state;
    pic_pkg::ack_state_t   ack_state;
    pic_pkg::ack_state_t   ack_next;
    logic                  inta_q;
    logic                  inta_fall;
    logic                  inta_rise;
    logic                  write_cmd;
    logic                  write_data;
    logic                  init_done;

    assign write_cmd  = write_enable & ~address;
    assign write_data = write_enable & address;
    assign init_done  = (init_state == pic_pkg::INIT_READY);

    // Address 0 decode, ICW1 wins over the OCWs
    assign write_icw1 = write_cmd & data_in[pic_pkg::ICW1_SELECT_BIT];
    assign write_ocw3 = write_cmd & init_done & ~data_in[pic_pkg::ICW1_SELECT_BIT]
                        & data_in[pic_pkg::OCW3_SELECT_BIT];
    assign write_ocw2 = write_cmd & init_done & ~data_in[pic_pkg::ICW1_SELECT_BIT]
                        & ~data_in[pic_pkg::OCW3_SELECT_BIT];

    // Address 1 depends on where initialization stands
    assign write_icw2 = write_data & (init_state == pic_pkg::INIT_ICW2);
    assign write_icw4 = write_data & (init_state == pic_pkg::INIT_ICW4);
    assign write_ocw1 = write_data & init_done;

    always_ff @(posedge clock) begin
        if (reset) begin
            init_state <= pic_pkg::INIT_READY;
        end else if (write_icw1) begin
            init_state <= pic_pkg::INIT_ICW2;
        end else if (write_icw2) begin
            init_state <= needs_icw4 ? pic_pkg::INIT_ICW4 : pic_pkg::INIT_READY;
        end else if (write_icw4) begin
            init_state <= pic_pkg::INIT_READY;
        end
    end

    assign inta_fall = inta_q & ~interrupt_acknowledge_n;
    assign inta_rise = ~inta_q & interrupt_acknowledge_n;

    always_comb begin
        case (ack_state)
            pic_pkg::ACK_IDLE:   ack_next = inta_fall ? pic_pkg::ACK_FIRST : ack_state;
            pic_pkg::ACK_FIRST:  ack_next = inta_rise ? pic_pkg::ACK_WAIT : ack_state;
            pic_pkg::ACK_WAIT:   ack_next = inta_fall ? pic_pkg::ACK_SECOND : ack_state;
            pic_pkg::ACK_SECOND: ack_next = inta_rise ? pic_pkg::ACK_IDLE : ack_state;
            default:             ack_next = pic_pkg::ACK_IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            inta_q    <= 1'b1;
            ack_state <= pic_pkg::ACK_IDLE;
        end else begin
            inta_q    <= interrupt_acknowledge_n;
            ack_state <= ack_next;
        end
    end

    assign latch_in_service   = (ack_state == pic_pkg::ACK_IDLE) & inta_fall;
    assign end_of_acknowledge = (ack_state == pic_pkg::ACK_SECOND) & inta_rise;
    assign vector_phase       = (ack_state == pic_pkg::ACK_SECOND);
    assign freeze             = (ack_state != pic_pkg::ACK_IDLE);

    // INT follows the resolver when idle and is held through an acknowledge
    always_ff @(posedge clock) begin
        if (reset || end_of_acknowledge) begin
            interrupt_to_cpu <= 1'b0;
        end else if (ack_state == pic_pkg::ACK_IDLE) begin
            interrupt_to_cpu <= request_pending;
        end
    end

endmodule

/* source/pic_command_registers.sv */
`timescale 1ns/1ps
// Initialization and operation configuration registers
// Strobes arrive already decoded and mutually exclusive
module pic_command_registers (
    input  logic                   clock,
    input  logic                   reset,
    input  pic_pkg::data_t         data_in,
    input  logic                   write_icw1,
    input  logic                   write_icw2,
    input  logic                   write_icw4,
    input  logic                   write_ocw1,
    input  logic                   write_ocw3,
    output logic                   level_triggered,
    output logic                   needs_icw4,
    output logic                   auto_eoi,
    output pic_pkg::vector_base_t  vector_base,
    output pic_pkg::irq_vec_t      interrupt_mask,
    output logic                   read_isr
);

    always_ff @(posedge clock) begin
        if (reset) begin
            level_triggered <= 1'b0;
            needs_icw4      <= 1'b0;
            auto_eoi        <= 1'b0;
            vector_base     <= '0;
            interrupt_mask  <= pic_pkg::IMR_RESET;
            read_isr        <= 1'b0;
        end else begin
            // A new ICW1 starts from an unmasked, non-AEOI setup
            if (write_icw1) begin
                level_triggered <= data_in[pic_pkg::ICW1_LTIM_BIT];
                needs_icw4      <= data_in[pic_pkg::ICW1_IC4_BIT];
                auto_eoi        <= 1'b0;
                interrupt_mask  <= '0;
            end
            // T7-T3 of the vector
            if (write_icw2) begin
                vector_base <= data_in[7:3];
            end
            if (write_icw4) begin
                auto_eoi <= data_in[pic_pkg::ICW4_AEOI_BIT];
            end
            if (write_ocw1) begin
                interrupt_mask <= data_in;
            end
            if (write_ocw3 && data_in[pic_pkg::OCW3_RR_BIT]) begin
                read_isr <= data_in[pic_pkg::OCW3_RIS_BIT];
            end
        end
    end

endmodule

/* source/pic_request_register.sv */
`timescale 1ns/1ps
// Interrupt request register, edge or level triggered
// Level mode expects the line to drop before the EOI of its level
module pic_request_register (
    input  logic               clock,
    input  logic               reset,
    input  pic_pkg::irq_vec_t  interrupt_request,
    input  logic               level_triggered,
    input  logic               freeze,
    input  logic               write_icw1,
    input  pic_pkg::irq_vec_t  clear_request,
    output pic_pkg::irq_vec_t  request_register
);

    pic_pkg::irq_vec_t  request_q;
    pic_pkg::irq_vec_t  request_rise;

    assign request_rise = interrupt_request & ~request_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            request_q <= '0;
        end else begin
            request_q <= interrupt_request;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || write_icw1) begin
            request_register <= '0;
        end else if (freeze) begin
            // No new requests during an acknowledge
            request_register <= request_register & ~clear_request;
        end else if (level_triggered) begin
            request_register <= interrupt_request & ~clear_request;
        end else begin
            request_register <= (request_register | request_rise) & ~clear_request;
        end
    end

endmodule

/* source/pic_priority_resolver.sv */
`timescale 1ns/1ps
// Fixed priority resolver, IR0 highest, fully nested
// One-hot vectors compare numerically, a lower value means a higher priority
module pic_priority_resolver (
    input  pic_pkg::irq_vec_t  request_register,
    input  pic_pkg::irq_vec_t  interrupt_mask,
    input  pic_pkg::irq_vec_t  in_service,
    output pic_pkg::irq_vec_t  selected_request,
    output logic               request_pending,
    output pic_pkg::irq_vec_t  highest_in_service
);

    pic_pkg::irq_vec_t  unmasked;

    assign unmasked = request_register & ~interrupt_mask;

    // Lowest set bit of each vector
    assign selected_request   = unmasked & (~unmasked + pic_pkg::irq_vec_t'(1));
    assign highest_in_service = in_service & (~in_service + pic_pkg::irq_vec_t'(1));

    // Must beat every level already in service
    assign request_pending = (selected_request != '0)
                             && ((highest_in_service == '0)
                                 || (selected_request < highest_in_service));

endmodule

/* source/pic_in_service.sv */
`timescale 1ns/1ps
// In-service register with acknowledged level and EOI handling
// A spurious acknowledge records level 7 without setting an ISR bit
module pic_in_service (
    input  logic                 clock,
    input  logic                 reset,
    input  pic_pkg::data_t       data_in,
    input  logic                 write_icw1,
    input  logic                 write_ocw2,
    input  logic                 latch_in_service,
    input  logic                 end_of_acknowledge,
    input  logic                 auto_eoi,
    input  pic_pkg::irq_vec_t    selected_request,
    input  pic_pkg::irq_vec_t    highest_in_service,
    output pic_pkg::irq_vec_t    in_service,
    output pic_pkg::irq_vec_t    clear_request,
    output pic_pkg::irq_level_t  acknowledged_level
);

    pic_pkg::irq_level_t  selected_level;
    pic_pkg::irq_vec_t    eoi_clear;
    logic [2:0]           ocw2_code;

    assign ocw2_code = data_in[pic_pkg::OCW2_CODE_MSB:pic_pkg::OCW2_CODE_LSB];

    always_comb begin
        selected_level = pic_pkg::SPURIOUS_LEVEL;
        for (int i = pic_pkg::NUM_IRQ - 1; i >= 0; i--) begin
            if (selected_request[i]) begin
                selected_level = pic_pkg::irq_level_t'(i);
            end
        end
    end

    // The request moves from IRR into ISR
    assign clear_request = latch_in_service ? selected_request : '0;

    always_comb begin
        eoi_clear = '0;
        if (end_of_acknowledge && auto_eoi) begin
            eoi_clear = pic_pkg::irq_vec_t'(1) << acknowledged_level;
        end
        if (write_ocw2 && (ocw2_code == pic_pkg::EOI_NON_SPECIFIC)) begin
            eoi_clear = eoi_clear | highest_in_service;
        end
        if (write_ocw2 && (ocw2_code == pic_pkg::EOI_SPECIFIC)) begin
            eoi_clear = eoi_clear | (pic_pkg::irq_vec_t'(1) << data_in[2:0]);
        end
    end

    always_ff @(posedge clock) begin
        if (reset || write_icw1) begin
            in_service <= '0;
        end else begin
            in_service <= (in_service | clear_request) & ~eoi_clear;
        end
    end

    always_ff @(posedge clock) begin
        if (latch_in_service) begin
            acknowledged_level <= selected_level;
        end
    end

endmodule

/* source/pic_data_output.sv */
`timescale 1ns/1ps
// Registered data output for the INTA vector and register read-back
// data_out is only meaningful while data_out_valid is high
module pic_data_output (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   read_enable,
    input  logic                   address,
    input  logic                   read_isr,
    input  pic_pkg::irq_vec_t      request_register,
    input  pic_pkg::irq_vec_t      in_service,
    input  pic_pkg::irq_vec_t      interrupt_mask,
    input  logic                   vector_phase,
    input  pic_pkg::vector_base_t  vector_base,
    input  pic_pkg::irq_level_t    acknowledged_level,
    output pic_pkg::data_t         data_out,
    output logic                   data_out_valid
);

    always_ff @(posedge clock) begin
        if (reset) begin
            data_out_valid <= 1'b0;
        end else begin
            data_out_valid <= vector_phase | read_enable;
        end
    end

    // Vector takes precedence over a read strobe
    always_ff @(posedge clock) begin
        if (vector_phase) begin
            data_out <= {vector_base, acknowledged_level};
        end else if (read_enable) begin
            if (address) begin
                data_out <= interrupt_mask;
            end else if (read_isr) begin
                data_out <= in_service;
            end else begin
                data_out <= request_register;
            end
        end
    end

endmodule

/* source/pic_top.sv */
`timescale 1ns/1ps
// Single 8086-mode interrupt controller with fixed priority, IR0 highest
// Register accesses are one-cycle strobes and read data is valid for one cycle only
// INTA pulses must be low and high for at least two clocks each
module pic_top (
    input  logic               clock,
    input  logic               reset,
    input  logic               write_enable,
    input  logic               read_enable,
    input  logic               address,
    input  pic_pkg::data_t     data_in,
    output pic_pkg::data_t     data_out,
    output logic               data_out_valid,
    input  pic_pkg::irq_vec_t  interrupt_request,
    output logic               interrupt_to_cpu,
    input  logic               interrupt_acknowledge_n
);

    logic                   write_icw1;
    logic                   write_icw2;
    logic                   write_icw4;
    logic                   write_ocw1;
    logic                   write_ocw2;
    logic                   write_ocw3;
    logic                   latch_in_service;
    logic                   end_of_acknowledge;
    logic                   vector_phase;
    logic                   freeze;
    logic                   request_pending;

    logic                   level_triggered;
    logic                   needs_icw4;
    logic                   auto_eoi;
    logic                   read_isr;
    pic_pkg::vector_base_t  vector_base;
    pic_pkg::irq_vec_t      interrupt_mask;

    pic_pkg::irq_vec_t      request_register;
    pic_pkg::irq_vec_t      selected_request;
    pic_pkg::irq_vec_t      highest_in_service;
    pic_pkg::irq_vec_t      in_service;
    pic_pkg::irq_vec_t      clear_request;
    pic_pkg::irq_level_t    acknowledged_level;

    // Port names match the internal nets throughout
    pic_sequencer u_sequencer (.*);

    pic_command_registers u_command_registers (.*);

    pic_request_register u_request_register (.*);

    pic_priority_resolver u_priority_resolver (.*);

    pic_in_service u_in_service (.*);

    pic_data_output u_data_output (.*);

endmodule

/* testbench/pic_properties.sv */
`timescale 1ns/1ps
// Concurrent checks on the acknowledge strobes and output valid of the controller
// Bound into every pic_top instance, reads internal nets by name
module pic_properties (
    input logic clock,
    input logic reset,
    input logic read_enable,
    input logic data_out_valid,
    input logic interrupt_to_cpu,
    input logic latch_in_service,
    input logic end_of_acknowledge,
    input logic freeze
);

    latch_single_pulse: assert property (@(posedge clock) disable iff (reset)
        latch_in_service |=> !latch_in_service)
        else $error("latch_in_service stayed high for more than one cycle");

    end_ack_single_pulse: assert property (@(posedge clock) disable iff (reset)
        end_of_acknowledge |=> !end_of_acknowledge)
        else $error("end_of_acknowledge stayed high for more than one cycle");

    // Valid only after a read strobe or while an acknowledge is in progress
    valid_has_source: assert property (@(posedge clock) disable iff (reset)
        data_out_valid |-> ($past(read_enable) || $past(freeze)))
        else $error("data_out_valid high without a read or an acknowledge");

    int_low_after_reset: assert property (@(posedge clock)
        $past(reset) |-> !interrupt_to_cpu)
        else $error("interrupt_to_cpu high in the cycle after reset");

endmodule

bind pic_top pic_properties u_properties (.*);

/* testbench/tb_pic.sv */
`timescale 1ns/1ps
// Directed tests of the interrupt controller in edge-triggered mode
// Inputs change and outputs are sampled on the falling clock edge
// Every test re-initializes the controller, ICW2 base is 8'h40
module tb_pic;

    logic               clock;
    logic               reset;
    logic               write_enable;
    logic               read_enable;
    logic               address;
    pic_pkg::data_t     data_in;
    pic_pkg::data_t     data_out;
    logic               data_out_valid;
    pic_pkg::irq_vec_t  interrupt_request;
    logic               interrupt_to_cpu;
    logic               interrupt_acknowledge_n;

    logic [31:0]        lfsr_state;
    pic_pkg::data_t     vector_base_byte;
    int                 error_count;

    pic_top UUT (.*);

    always #10 clock = ~clock;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic logic [2:0] random_level();
        logic [2:0] value;
        value = '0;
        for (int i = 0; i < 3; i++) begin
            value = {value[1:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return value;
    endfunction

    // Upper five bits from ICW2, level in the low three
    function automatic pic_pkg::data_t expected_vector(input logic [2:0] level);
        return {vector_base_byte[7:3], level};
    endfunction

    task automatic check_equal(input string name, input logic [7:0] got,
                               input logic [7:0] expected);
        if (got !== expected) begin
            $display("FAIL %s: expected 0x%h, got 0x%h", name, expected, got);
            error_count++;
        end
    endtask

    task automatic bus_write(input logic addr, input pic_pkg::data_t value);
        @(negedge clock);
        write_enable = 1'b1;
        address = addr;
        data_in = value;
        @(negedge clock);
        write_enable = 1'b0;
    endtask

    task automatic bus_read(input logic addr, output pic_pkg::data_t value);
        int cycles;
        cycles = 0;
        value = '0;
        @(negedge clock);
        read_enable = 1'b1;
        address = addr;
        @(negedge clock);
        read_enable = 1'b0;
        while (!data_out_valid && cycles < 50) begin
            @(negedge clock);
            cycles++;
        end
        if (data_out_valid) begin
            if (cycles != 0) begin
                $display("read data at address %0d came %0d cycles late", addr, cycles);
                error_count++;
            end
            value = data_out;
            // Read data lasts one cycle only
            @(negedge clock);
            check_equal("data_out_valid", {7'd0, data_out_valid}, 8'h00);
        end else begin
            $display("read at address %0d returned no valid data", addr);
            error_count++;
        end
    endtask

    task automatic wait_for_interrupt();
        int cycles;
        cycles = 0;
        while (!interrupt_to_cpu && cycles < 3) begin
            @(negedge clock);
            cycles++;
        end
        if (!interrupt_to_cpu) begin
            $display("interrupt_to_cpu did not rise within 3 cycles");
            error_count++;
        end
    endtask

    task automatic expect_no_interrupt(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clock);
            check_equal("interrupt_to_cpu", {7'd0, interrupt_to_cpu}, 8'h00);
            if (interrupt_to_cpu) begin
                break;
            end
        end
    endtask

    // Two pulses, 3 cycles low and 3 high, vector taken in the second
    task automatic inta_sequence(output pic_pkg::data_t vector);
        logic captured;
        captured = 1'b0;
        vector = '0;
        @(negedge clock);
        for (int pulse = 0; pulse < 2; pulse++) begin
            interrupt_acknowledge_n = 1'b0;
            for (int i = 0; i < 3; i++) begin
                @(negedge clock);
                if (pulse == 1 && data_out_valid && !captured) begin
                    vector = data_out;
                    captured = 1'b1;
                end
            end
            interrupt_acknowledge_n = 1'b1;
            repeat (3) @(negedge clock);
        end
        if (!captured) begin
            $display("no vector was driven during the second acknowledge pulse");
            error_count++;
        end
    endtask

    // ICW1 edge-triggered with ICW4, then ICW2 and ICW4
    task automatic init_controller(input pic_pkg::data_t icw4);
        bus_write(1'b0, 8'h11);
        bus_write(1'b1, vector_base_byte);
        bus_write(1'b1, icw4);
    endtask

    task automatic test_reset_and_init();
        pic_pkg::data_t value;
        check_equal("interrupt_to_cpu", {7'd0, interrupt_to_cpu}, 8'h00);
        bus_read(1'b1, value);
        check_equal("data_out", value, 8'hFF);
        init_controller(8'h01);
        bus_read(1'b1, value);
        check_equal("data_out", value, 8'h00);
        bus_write(1'b1, 8'hA5);
        bus_read(1'b1, value);
        check_equal("data_out", value, 8'hA5);
    endtask

    task automatic test_priority_and_vector();
        logic [2:0]     first_level;
        logic [2:0]     second_level;
        logic [2:0]     low_level;
        logic [2:0]     high_level;
        pic_pkg::data_t ack_vector;
        first_level = random_level();
        second_level = random_level();
        if (second_level == first_level) begin
            second_level = first_level + 3'd1;
        end
        low_level = (first_level < second_level) ? first_level : second_level;
        high_level = (first_level < second_level) ? second_level : first_level;
        init_controller(8'h01);
        @(negedge clock);
        interrupt_request = (8'h01 << low_level) | (8'h01 << high_level);
        wait_for_interrupt();
        inta_sequence(ack_vector);
        check_equal("data_out", ack_vector, expected_vector(low_level));
        // Non-specific EOI
        bus_write(1'b0, 8'h20);
        wait_for_interrupt();
        inta_sequence(ack_vector);
        check_equal("data_out", ack_vector, expected_vector(high_level));
        bus_write(1'b0, 8'h20);
        interrupt_request = '0;
    endtask

    task automatic test_masking();
        pic_pkg::data_t value;
        init_controller(8'h01);
        bus_write(1'b1, 8'h20);
        @(negedge clock);
        interrupt_request = 8'h20;
        expect_no_interrupt(20);
        // OCW3 read IRR
        bus_write(1'b0, 8'h0A);
        bus_read(1'b0, value);
        check_equal("data_out", value, 8'h20);
        interrupt_request = '0;
    endtask

    task automatic test_in_service_and_specific_eoi();
        pic_pkg::data_t value;
        pic_pkg::data_t ack_vector;
        init_controller(8'h01);
        @(negedge clock);
        interrupt_request = 8'h08;
        wait_for_interrupt();
        inta_sequence(ack_vector);
        check_equal("data_out", ack_vector, expected_vector(3'd3));
        interrupt_request = '0;
        // OCW3 read ISR
        bus_write(1'b0, 8'h0B);
        bus_read(1'b0, value);
        check_equal("data_out", value, 8'h08);
        bus_write(1'b0, 8'h63);
        bus_read(1'b0, value);
        check_equal("data_out", value, 8'h00);
    endtask

    task automatic test_nesting();
        pic_pkg::data_t ack_vector;
        init_controller(8'h01);
        @(negedge clock);
        interrupt_request = 8'h10;
        wait_for_interrupt();
        inta_sequence(ack_vector);
        check_equal("data_out", ack_vector, expected_vector(3'd4));
        // IR6 ranks below IR4 in service
        interrupt_request = 8'h40;
        expect_no_interrupt(10);
        interrupt_request = 8'h42;
        wait_for_interrupt();
        inta_sequence(ack_vector);
        check_equal("data_out", ack_vector, expected_vector(3'd1));
        interrupt_request = '0;
    endtask

    task automatic test_auto_eoi();
        pic_pkg::data_t value;
        pic_pkg::data_t ack_vector;
        init_controller(8'h03);
        @(negedge clock);
        interrupt_request = 8'h04;
        wait_for_interrupt();
        inta_sequence(ack_vector);
        check_equal("data_out", ack_vector, expected_vector(3'd2));
        interrupt_request = '0;
        bus_write(1'b0, 8'h0B);
        bus_read(1'b0, value);
        check_equal("data_out", value, 8'h00);
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        write_enable = 1'b0;
        read_enable = 1'b0;
        address = 1'b0;
        data_in = '0;
        interrupt_request = '0;
        interrupt_acknowledge_n = 1'b1;
        lfsr_state = 32'hb25d;
        vector_base_byte = 8'h40;
        error_count = 0;
        repeat (10) @(negedge clock);
        reset = 1'b0;
        test_reset_and_init();
        test_priority_and_vector();
        test_masking();
        test_in_service_and_specific_eoi();
        test_nesting();
        test_auto_eoi();
        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* sources.f */
source/pic_pkg.sv
source/pic_sequencer.sv
source/pic_command_registers.sv
source/pic_request_register.sv
source/pic_priority_resolver.sv
source/pic_in_service.sv
source/pic_data_output.sv
source/pic_top.sv
testbench/pic_properties.sv
testbench/tb_pic.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_pic -o tb_pic
output=$(./obj_dir/tb_pic)
echo "$output"

if grep -qx "sim passed" <<< "$output"; then
    exit 0
fi
exit 1
